// ==== ddr_access_pkg.sv ====
//////////////////////////////////////////////////
// DDR access package
// Shared widths, opcode and command/response types
//////////////////////////////////////////////////
`default_nettype none

package ddr_access_pkg;

    // Avalon address width in bits
    parameter int addr_w = 32;

    // Avalon data width in bits
    parameter int data_w = 32;

    // One byte enable per data byte
    parameter int mask_w = 4;

    // Client opcode, a single bit on the wire
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Client command, 69 bits
    // The mask only matters for writes, reads always fetch the whole word
    typedef struct packed {
        mem_op_e             op;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
        logic [mask_w-1:0]   mask;
    } mem_cmd_t;

    // Completion returned to the client, 65 bits
    // Opcode and address echo the command so the client can match them up
    // Read data is zero for a write completion
    typedef struct packed {
        mem_op_e             op;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== cmd_credit_queue.sv ====
//////////////////////////////////////////////////
// Command queue with credit return
// Buffers client commands and hands back a credit per dequeue
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmd_credit_queue #(
    parameter int cmd_depth = 4
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    // Client side, one credit is spent per cmd_valid cycle
    input  wire logic                   cmd_valid,
    input  wire ddr_access_pkg::mem_cmd_t cmd,
    output logic                        cmd_credit,
    // Toward the Avalon master
    output logic                        q_valid,
    input  wire logic                   q_ready,
    output ddr_access_pkg::mem_cmd_t    q_cmd
);

    import ddr_access_pkg::*;

    // Pointer width is kept at one bit at least so a depth of one still compiles
    localparam int ptr_w = (cmd_depth > 1) ? $clog2(cmd_depth) : 1;
    localparam int cnt_w = $clog2(cmd_depth + 1);

    // Storage ring, no reset needed on payload
    mem_cmd_t           mem [cmd_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    // Entries held in the ring, the output register is not counted here
    logic [cnt_w-1:0]   mem_count;
    // Ring head moves into the output register
    logic               load;

    // Advance a pointer and wrap at the last entry
    // Wrapping by compare keeps depths that are not a power of two correct
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        logic [ptr_w-1:0] last;
        last = ptr_w'(cmd_depth - 1);
        return (p == last) ? '0 : p + 1'b1;
    endfunction

    // Refill the output register when it is empty or is being taken this cycle
    assign load = (mem_count != '0) && (!q_valid || q_ready);

    // Payload path
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            mem[wr_ptr] <= cmd;
        end
        if (load) begin
            q_cmd <= mem[rd_ptr];
        end
    end

    // Control path
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            mem_count  <= '0;
            q_valid    <= 1'b0;
            cmd_credit <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (load) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            mem_count <= mem_count + cnt_w'(cmd_valid) - cnt_w'(load);

            // Output register holds its entry until the master takes it
            if (load) begin
                q_valid <= 1'b1;
            end else if (q_ready) begin
                q_valid <= 1'b0;
            end

            // One credit goes back in the cycle after each dequeue
            cmd_credit <= q_valid && q_ready;
        end
    end

    // The client may only push while it holds credit, so the queue is never
    // full when cmd_valid arrives
    // Credit returns lag the dequeue by a cycle, which makes this a check
    // on the client's bookkeeping across the whole port
    assert property (@(posedge clk) disable iff (reset)
        cmd_valid |-> (int'(mem_count) + int'(q_valid)) < cmd_depth)
        else $error("cmd_credit_queue: push while queue full, client credit violated");

endmodule

`default_nettype wire

// ==== avalon_mm_master.sv ====
//////////////////////////////////////////////////
// Avalon-MM single beat master
// Issues one command at a time and captures its completion
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module avalon_mm_master (
    input  wire logic                       clk,
    input  wire logic                       reset,
    // Command from the queue
    input  wire logic                       q_valid,
    output logic                            q_ready,
    input  wire ddr_access_pkg::mem_cmd_t   q_cmd,
    // Completion toward the response buffer
    output logic                            m_valid,
    input  wire logic                       m_ready,
    output ddr_access_pkg::mem_rsp_t        m_rsp,
    // Avalon-MM master port
    output logic                                    avm_read,
    output logic                                    avm_write,
    output logic [ddr_access_pkg::addr_w-1:0]       avm_address,
    output logic [ddr_access_pkg::data_w-1:0]       avm_writedata,
    output logic [ddr_access_pkg::mask_w-1:0]       avm_byteenable,
    output logic [10:0]                             avm_burstcount,
    input  wire logic [ddr_access_pkg::data_w-1:0]  avm_readdata,
    input  wire logic                               avm_readdatavalid,
    input  wire logic                               avm_waitrequest
);

    import ddr_access_pkg::*;

    // Access sequencing
    // idle       waits for a queued command
    // write_req  holds write until the slave drops waitrequest
    // read_req   holds read until the slave drops waitrequest
    // read_wait  waits for readdatavalid
    // respond    presents the completion until the buffer takes it
    typedef enum logic [2:0] {
        idle,
        write_req,
        read_req,
        read_wait,
        respond
    } state_e;

    state_e             state;

    // Command held for the whole access, which keeps the Avalon request stable
    mem_cmd_t           cmd_reg;
    // Captured read data, zero for writes
    logic [data_w-1:0]  rdata_reg;

    // Only one access is in flight, so a new command is taken only from idle
    assign q_ready = (state == idle);

    // State register
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (q_valid) begin
                        state <= (q_cmd.op == MEM_WRITE) ? write_req : read_req;
                    end
                end
                write_req: begin
                    // Write is done once the slave accepts it, nothing comes back
                    if (!avm_waitrequest) begin
                        state <= respond;
                    end
                end
                read_req: begin
                    if (!avm_waitrequest) begin
                        state <= read_wait;
                    end
                end
                read_wait: begin
                    if (avm_readdatavalid) begin
                        state <= respond;
                    end
                end
                respond: begin
                    // Stall here while the response buffer is full
                    if (m_ready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (state == idle && q_valid) begin
            cmd_reg   <= q_cmd;
            rdata_reg <= '0;
        end
        if (state == read_wait && avm_readdatavalid) begin
            rdata_reg <= avm_readdata;
        end
    end

    // Avalon request is decoded from the state alone
    assign avm_read      = (state == read_req);
    assign avm_write     = (state == write_req);
    assign avm_address   = cmd_reg.addr;
    assign avm_writedata = cmd_reg.wdata;

    // Writes carry the client mask, reads fetch all bytes
    assign avm_byteenable = (cmd_reg.op == MEM_WRITE) ? cmd_reg.mask : '1;

    // Single beat only
    assign avm_burstcount = 11'd1;

    // Completion echoes opcode and address of the command
    assign m_valid     = (state == respond);
    assign m_rsp.op    = cmd_reg.op;
    assign m_rsp.addr  = cmd_reg.addr;
    assign m_rsp.rdata = rdata_reg;

    // A single master port never asks for both directions at once
    assert property (@(posedge clk) disable iff (reset)
        !(avm_read && avm_write))
        else $error("avalon_mm_master: read and write asserted together");

    // While the slave stalls, the request and its payload must not move
    assert property (@(posedge clk) disable iff (reset)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_read) && $stable(avm_write) && $stable(avm_address) &&
            $stable(avm_writedata) && $stable(avm_byteenable))
        else $error("avalon_mm_master: request changed under waitrequest");

endmodule

`default_nettype wire

// ==== rsp_credit_buffer.sv ====
//////////////////////////////////////////////////
// Response buffer with credit gating
// Holds completions and sends them as client credit allows
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rsp_credit_buffer #(
    parameter int rsp_depth = 2
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    // Completion from the Avalon master
    input  wire logic                       m_valid,
    output logic                            m_ready,
    input  wire ddr_access_pkg::mem_rsp_t   m_rsp,
    // Client side, one response per credit
    output logic                            rsp_valid,
    output ddr_access_pkg::mem_rsp_t        rsp,
    input  wire logic                       rsp_credit
);

    import ddr_access_pkg::*;

    localparam int ptr_w    = (rsp_depth > 1) ? $clog2(rsp_depth) : 1;
    localparam int cnt_w    = $clog2(rsp_depth + 1);
    // Wide enough for any grant pattern a sane client produces
    localparam int credit_w = 8;

    mem_rsp_t               mem [rsp_depth];
    logic [ptr_w-1:0]       wr_ptr;
    logic [ptr_w-1:0]       rd_ptr;
    logic [cnt_w-1:0]       count;
    // Credits granted by the client and not yet used
    logic [credit_w-1:0]    credit;
    logic                   push;
    logic                   pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        logic [ptr_w-1:0] last;
        last = ptr_w'(rsp_depth - 1);
        return (p == last) ? '0 : p + 1'b1;
    endfunction

    // A full buffer holds the master in its respond state
    assign m_ready = (count < cnt_w'(rsp_depth));
    assign push    = m_valid && m_ready;

    // Send only with both an entry and a credit in hand
    assign rsp_valid = (count != '0) && (credit != '0);
    assign pop       = rsp_valid;
    assign rsp       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= m_rsp;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count  <= count + cnt_w'(push) - cnt_w'(pop);
            // A grant and a send in the same cycle cancel out
            credit <= credit + credit_w'(rsp_credit) - credit_w'(pop);
        end
    end

    // A grant must never wrap the credit counter
    assert property (@(posedge clk) disable iff (reset)
        rsp_credit && !pop |-> credit != '1)
        else $error("rsp_credit_buffer: response credit counter overflow");

endmodule

`default_nettype wire

// ==== ddr_access_top.sv ====
//////////////////////////////////////////////////
// DDR access engine top level
// Command queue, Avalon master and response buffer in a chain
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ddr_access_top #(
    parameter int cmd_depth = 4,
    parameter int rsp_depth = 2
) (
    input  wire logic                               clk,
    input  wire logic                               reset,
    // Client command port
    input  wire logic                               cmd_valid,
    input  wire ddr_access_pkg::mem_cmd_t           cmd,
    output logic                                    cmd_credit,
    // Client response port
    output logic                                    rsp_valid,
    output ddr_access_pkg::mem_rsp_t                rsp,
    input  wire logic                               rsp_credit,
    // Avalon-MM master port toward the DDR3 controller
    output logic                                    avm_read,
    output logic                                    avm_write,
    output logic [ddr_access_pkg::addr_w-1:0]       avm_address,
    output logic [ddr_access_pkg::data_w-1:0]       avm_writedata,
    output logic [ddr_access_pkg::mask_w-1:0]       avm_byteenable,
    output logic [10:0]                             avm_burstcount,
    input  wire logic [ddr_access_pkg::data_w-1:0]  avm_readdata,
    input  wire logic                               avm_readdatavalid,
    input  wire logic                               avm_waitrequest
);

    import ddr_access_pkg::*;

    // Queue to master link
    logic       q_valid;
    logic       q_ready;
    mem_cmd_t   q_cmd;

    // Master to buffer link
    logic       m_valid;
    logic       m_ready;
    mem_rsp_t   m_rsp;

    cmd_credit_queue #(
        .cmd_depth (cmd_depth)
    ) i_cmd_credit_queue (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .q_valid    (q_valid),
        .q_ready    (q_ready),
        .q_cmd      (q_cmd)
    );

    avalon_mm_master i_avalon_mm_master (
        .clk               (clk),
        .reset             (reset),
        .q_valid           (q_valid),
        .q_ready           (q_ready),
        .q_cmd             (q_cmd),
        .m_valid           (m_valid),
        .m_ready           (m_ready),
        .m_rsp             (m_rsp),
        .avm_read          (avm_read),
        .avm_write         (avm_write),
        .avm_address       (avm_address),
        .avm_writedata     (avm_writedata),
        .avm_byteenable    (avm_byteenable),
        .avm_burstcount    (avm_burstcount),
        .avm_readdata      (avm_readdata),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_waitrequest   (avm_waitrequest)
    );

    rsp_credit_buffer #(
        .rsp_depth (rsp_depth)
    ) i_rsp_credit_buffer (
        .clk        (clk),
        .reset      (reset),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_rsp      (m_rsp),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

endmodule

`default_nettype wire

// ==== tb_avalon_mem.sv ====
//////////////////////////////////////////////////
// Avalon-MM slave memory model
// Random waitrequest stalls and random read latency
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_avalon_mem (
    input  wire logic        clk,
    input  wire logic        reset,
    // Random word from the testbench top, refreshed on every falling edge
    input  wire logic [31:0] rnd,
    input  wire logic        avm_read,
    input  wire logic        avm_write,
    input  wire logic [31:0] avm_address,
    input  wire logic [31:0] avm_writedata,
    input  wire logic [3:0]  avm_byteenable,
    output logic [31:0]      avm_readdata,
    output logic             avm_readdatavalid,
    output logic             avm_waitrequest
);

    // Sparse storage, an unwritten word reads as its inverted address
    logic [31:0] store [logic [31:0]];
    // Wait cycles still owed to the current request
    int          stall_cnt;
    // Cycles until read data returns, zero while no read is pending
    int          lat_left;
    logic [31:0] rd_word;
    logic [31:0] wr_word;
    logic        accept;

    // The request is taken on the edge where waitrequest is low
    assign accept = (avm_read || avm_write) && !avm_waitrequest;

    function logic [31:0] fetch(input logic [31:0] a);
        return store.exists(a) ? store[a] : ~a;
    endfunction

    // Sampling side, everything here looks at values settled since the falling edge
    always @(posedge clk) begin
        if (reset) begin
            stall_cnt <= 0;
            lat_left  <= 0;
        end else begin
            if (accept && avm_write) begin
                wr_word = fetch(avm_address);
                for (int b = 0; b < 4; b++) begin
                    if (avm_byteenable[b]) begin
                        wr_word[8*b +: 8] = avm_writedata[8*b +: 8];
                    end
                end
                store[avm_address] = wr_word;
            end
            // Latency of 1 to 4 cycles after acceptance
            if (accept && avm_read) begin
                rd_word  <= fetch(avm_address);
                lat_left <= 1 + int'(rnd[3:2]);
            end else if (lat_left != 0) begin
                lat_left <= lat_left - 1;
            end
            // A stalled request burns one wait cycle
            // Otherwise draw 0 to 3 wait cycles for the next request
            if ((avm_read || avm_write) && avm_waitrequest) begin
                stall_cnt <= stall_cnt - 1;
            end else begin
                stall_cnt <= int'(rnd[1:0]);
            end
        end
    end

    // Driving side, outputs only change on the falling edge
    initial begin
        avm_waitrequest   = 1'b1;
        avm_readdatavalid = 1'b0;
        avm_readdata      = '0;
        forever begin
            @(negedge clk);
            avm_waitrequest   = (stall_cnt != 0);
            avm_readdatavalid = (lat_left == 1);
            avm_readdata      = (lat_left == 1) ? rd_word : '0;
        end
    end

endmodule

`default_nettype wire

// ==== tb_ddr_checker.sv ====
//////////////////////////////////////////////////
// DDR access checker
// Predicts responses from a shadow memory and checks credits
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_checker #(
    parameter int cmd_depth = 4
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       cmd_valid,
    input  wire ddr_access_pkg::mem_cmd_t   cmd,
    input  wire logic                       cmd_credit,
    input  wire logic                       rsp_valid,
    input  wire ddr_access_pkg::mem_rsp_t   rsp,
    input  wire logic                       rsp_credit,
    // Avalon request side of the DUT
    input  wire logic                                   avm_read,
    input  wire logic                                   avm_write,
    input  wire logic [ddr_access_pkg::mask_w-1:0]      avm_byteenable,
    input  wire logic [10:0]                            avm_burstcount,
    // Raised once the client is finished to trigger the count check
    input  wire logic                       done,
    output int                              value_errors,
    output int                              protocol_errors,
    output int                              rsp_count
);

    import ddr_access_pkg::*;

    // Shadow of the DDR contents in command order
    logic [data_w-1:0] shadow [logic [addr_w-1:0]];
    // Predicted responses, oldest first
    mem_rsp_t          expected_q [$];
    mem_rsp_t          exp_rsp;
    logic [data_w-1:0] word;
    int                cmd_count;
    // Credits held by the client on each port
    int                cmd_cr;
    int                rsp_cr;
    logic              count_checked;

    function logic [data_w-1:0] shadow_word(input logic [addr_w-1:0] a);
        return shadow.exists(a) ? shadow[a] : ~a;
    endfunction

    task compare_field(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("Fail: time %0t, %s = %h, expected %h", $time, name, got, want);
            value_errors++;
        end
    endtask

    task protocol_error(input string what);
        $display("Error at time %0t: %s", $time, what);
        protocol_errors++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            cmd_count       = 0;
            rsp_count       = 0;
            cmd_cr          = cmd_depth;
            rsp_cr          = 0;
            value_errors    = 0;
            protocol_errors = 0;
            count_checked   = 1'b0;
            expected_q.delete();
        end else begin
            // A credit returned this cycle may already be spent in the same cycle
            cmd_cr = cmd_cr + int'(cmd_credit);
            if (cmd_cr > cmd_depth) begin
                protocol_error("client holds more command credits than queue entries");
            end
            if (cmd_valid) begin
                if (cmd_cr == 0) begin
                    protocol_error("client sent a command while holding no credit");
                end
                cmd_cr--;
                cmd_count++;
                word          = shadow_word(cmd.addr);
                exp_rsp.op    = cmd.op;
                exp_rsp.addr  = cmd.addr;
                exp_rsp.rdata = (cmd.op == MEM_WRITE) ? '0 : word;
                expected_q.push_back(exp_rsp);
                if (cmd.op == MEM_WRITE) begin
                    for (int b = 0; b < mask_w; b++) begin
                        if (cmd.mask[b]) begin
                            word[8*b +: 8] = cmd.wdata[8*b +: 8];
                        end
                    end
                    shadow[cmd.addr] = word;
                end
            end

            // Every Avalon request is a single beat and reads enable all four bytes
            if (avm_read || avm_write) begin
                compare_field("avm_burstcount", 32'(avm_burstcount), 32'd1);
            end
            if (avm_read) begin
                compare_field("avm_byteenable", 32'(avm_byteenable), 32'hf);
            end

            if (rsp_valid) begin
                rsp_count++;
                if (rsp_cr == 0) begin
                    protocol_error("response sent while the client had granted no credit");
                end
                if (expected_q.size() == 0) begin
                    protocol_error("response arrived with no command outstanding");
                end else begin
                    exp_rsp = expected_q.pop_front();
                    compare_field("rsp.op", 32'(rsp.op), 32'(exp_rsp.op));
                    compare_field("rsp.addr", rsp.addr, exp_rsp.addr);
                    compare_field("rsp.rdata", rsp.rdata, exp_rsp.rdata);
                end
            end
            // The buffer spends the credit it held before this cycle's grant
            rsp_cr = rsp_cr + int'(rsp_credit) - int'(rsp_valid);

            if (done && !count_checked) begin
                count_checked = 1'b1;
                if (cmd_count != rsp_count) begin
                    protocol_error($sformatf("%0d commands sent but %0d responses received",
                                             cmd_count, rsp_count));
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_ddr_access.sv ====
//////////////////////////////////////////////////
// DDR access engine testbench
// Table-driven client, credit bookkeeping, memory model
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_access;

    import ddr_access_pkg::*;

    localparam int cmd_depth      = 4;
    localparam int rsp_depth      = 2;
    localparam int num_rows       = 32;
    // Forty cycles per row plus reset and drain
    localparam int timeout_cycles = num_rows * 40 + 20;

    // One client command where pause withholds response credit for that many cycles
    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        logic [7:0]  pause;
    } row_t;

    logic        clk;
    logic        reset;
    logic        cmd_valid;
    mem_cmd_t    cmd;
    logic        cmd_credit;
    logic        rsp_valid;
    mem_rsp_t    rsp;
    logic        rsp_credit;
    logic        avm_read;
    logic        avm_write;
    logic [31:0] avm_address;
    logic [31:0] avm_writedata;
    logic [3:0]  avm_byteenable;
    logic [10:0] avm_burstcount;
    logic [31:0] avm_readdata;
    logic        avm_readdatavalid;
    logic        avm_waitrequest;
    logic [31:0] rnd;
    logic        done;
    int          value_errors;
    int          protocol_errors;
    int          rsp_count;

    row_t        stim [num_rows];
    integer      seed = 32'h321d66e6;
    // Client bookkeeping
    int          credits;
    int          next_row;
    int          hold;
    int          open_grants;

    task automatic set_row(input int idx, input mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] mask,
                           input logic [7:0] pause);
        stim[idx].op    = op;
        stim[idx].addr  = addr;
        stim[idx].data  = data;
        stim[idx].mask  = mask;
        stim[idx].pause = pause;
    endtask

    task automatic build_table();
        logic [31:0] r;
        // Full write and read back, then an unwritten word and partial masks
        set_row(0, MEM_WRITE, 32'h0000_0100, 32'h1234_5678, 4'hf, 8'd0);
        set_row(1, MEM_READ, 32'h0000_0100, 32'h0, 4'hf, 8'd0);
        set_row(2, MEM_READ, 32'h0000_0200, 32'h0, 4'hf, 8'd0);
        set_row(3, MEM_WRITE, 32'h0000_0200, 32'haabb_ccdd, 4'h5, 8'd0);
        set_row(4, MEM_READ, 32'h0000_0200, 32'h0, 4'hf, 8'd0);
        set_row(5, MEM_WRITE, 32'h0000_0100, 32'h9900_0000, 4'h8, 8'd0);
        set_row(6, MEM_READ, 32'h0000_0100, 32'h0, 4'hf, 8'd0);
        set_row(7, MEM_WRITE, 32'h0000_0300, 32'hdead_beef, 4'h0, 8'd0);
        set_row(8, MEM_READ, 32'h0000_0300, 32'h0, 4'hf, 8'd0);
        // Credits withheld here, so the buffer fills and the stall reaches the queue
        set_row(9, MEM_WRITE, 32'h0000_0400, 32'h1111_1111, 4'hf, 8'd60);
        set_row(10, MEM_WRITE, 32'h0000_0404, 32'h2222_2222, 4'hf, 8'd0);
        set_row(11, MEM_WRITE, 32'h0000_0408, 32'h3333_3333, 4'hf, 8'd0);
        set_row(12, MEM_READ, 32'h0000_0400, 32'h0, 4'hf, 8'd0);
        set_row(13, MEM_READ, 32'h0000_0404, 32'h0, 4'hf, 8'd0);
        set_row(14, MEM_READ, 32'h0000_0408, 32'h0, 4'hf, 8'd0);
        set_row(15, MEM_READ, 32'h0000_040c, 32'h0, 4'hf, 8'd0);
        // Random mix over four words keeps reads close behind writes
        for (int i = 16; i < num_rows; i++) begin
            r = $random(seed);
            set_row(i, mem_op_e'(r[0]), 32'h0000_0500 | {26'd0, r[5:4], 4'd0},
                    $random(seed), r[11:8], 8'd0);
        end
    endtask

    // One falling edge of client activity on both ports
    task automatic drive_cycle();
        rnd = $random(seed);
        if (cmd_credit) begin
            credits++;
        end
        if (next_row < num_rows && credits > 0) begin
            cmd_valid = 1'b1;
            cmd.op    = stim[next_row].op;
            cmd.addr  = stim[next_row].addr;
            cmd.wdata = stim[next_row].data;
            cmd.mask  = stim[next_row].mask;
            credits--;
            if (stim[next_row].pause != 8'd0) begin
                hold = int'(stim[next_row].pause);
            end
            next_row++;
        end else begin
            cmd_valid = 1'b0;
        end
        // Response credits go out on random cycles with never more than three unused
        if (rsp_valid) begin
            open_grants--;
        end
        if (hold > 0) begin
            hold--;
            rsp_credit = 1'b0;
        end else if (open_grants < 3 && rnd[4]) begin
            rsp_credit = 1'b1;
            open_grants++;
        end else begin
            rsp_credit = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset       = 1'b1;
        cmd_valid   = 1'b0;
        cmd         = '0;
        rsp_credit  = 1'b0;
        done        = 1'b0;
        rnd         = '0;
        credits     = cmd_depth;
        next_row    = 0;
        hold        = 0;
        open_grants = 0;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (rsp_count < num_rows) begin
            @(negedge clk);
            drive_cycle();
        end
        @(negedge clk);
        cmd_valid  = 1'b0;
        rsp_credit = 1'b0;
        done       = 1'b1;
        repeat (2) @(negedge clk);
        $display("Closing counts: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: only %0d of %0d responses after %0d cycles",
                 rsp_count, num_rows, timeout_cycles);
        $display("Closing counts: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        $display("Test failed");
        $finish;
    end

    ddr_access_top #(
        .cmd_depth (cmd_depth),
        .rsp_depth (rsp_depth)
    ) i_ddr_access_top (
        .clk               (clk),
        .reset             (reset),
        .cmd_valid         (cmd_valid),
        .cmd               (cmd),
        .cmd_credit        (cmd_credit),
        .rsp_valid         (rsp_valid),
        .rsp               (rsp),
        .rsp_credit        (rsp_credit),
        .avm_read          (avm_read),
        .avm_write         (avm_write),
        .avm_address       (avm_address),
        .avm_writedata     (avm_writedata),
        .avm_byteenable    (avm_byteenable),
        .avm_burstcount    (avm_burstcount),
        .avm_readdata      (avm_readdata),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_waitrequest   (avm_waitrequest)
    );

    tb_avalon_mem i_avalon_mem (
        .clk               (clk),
        .reset             (reset),
        .rnd               (rnd),
        .avm_read          (avm_read),
        .avm_write         (avm_write),
        .avm_address       (avm_address),
        .avm_writedata     (avm_writedata),
        .avm_byteenable    (avm_byteenable),
        .avm_readdata      (avm_readdata),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_waitrequest   (avm_waitrequest)
    );

    tb_ddr_checker #(
        .cmd_depth (cmd_depth)
    ) i_checker (
        .clk             (clk),
        .reset           (reset),
        .cmd_valid       (cmd_valid),
        .cmd             (cmd),
        .cmd_credit      (cmd_credit),
        .rsp_valid       (rsp_valid),
        .rsp             (rsp),
        .rsp_credit      (rsp_credit),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_byteenable  (avm_byteenable),
        .avm_burstcount  (avm_burstcount),
        .done            (done),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .rsp_count       (rsp_count)
    );

endmodule

`default_nettype wire

// ==== filelist.f ====
ddr_access_pkg.sv
cmd_credit_queue.sv
avalon_mm_master.sv
rsp_credit_buffer.sv
ddr_access_top.sv
tb_avalon_mem.sv
tb_ddr_checker.sv
tb_ddr_access.sv

// ==== Makefile ====
# Verilator build and run for the DDR access engine testbench

SRCS := $(shell cat filelist.f)

# Rebuilt only when the file list or one of its sources changes
obj_dir/sim_ddr_access: filelist.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps -f filelist.f \
		--top-module tb_ddr_access -o sim_ddr_access

run: obj_dir/sim_ddr_access
	./obj_dir/sim_ddr_access | tee sim.log
	grep -q "^Test completed successfully$$" sim.log

# Checks the log of the last run without running again
check:
	grep -q "^Test completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run check clean
